// File: run_sim.sh
#!/usr/bin/env bash
# build and run the frontend testbench with verilator
set -u

cd "$(dirname "$0")"

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_frontend \
    --Mdir "$build_dir" -o tb_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_frontend" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi

// File: sim.f
src/rv_isa_pkg.sv
src/core_pkg.sv
src/stage_if.sv
src/fetch_unit.sv
src/imem_stage.sv
src/decode_unit.sv
src/frontend_top.sv
tests/clock_gen.sv
tests/tb_frontend.sv

// File: src/core_pkg.sv
package core_pkg;

    typedef logic [rv_isa_pkg::XLEN-1:0] pc_t;

    // bumped on every redirect, wraps
    typedef logic [1:0] epoch_t;

    typedef struct packed {
        pc_t base_addr;
        pc_t offset;
    } redirect_t;

    typedef struct packed {
        pc_t    pc;
        epoch_t epoch;
    } fetch_op_t;

    typedef struct packed {
        pc_t                          pc;
        rv_isa_pkg::op_class_t        op_class;
        rv_isa_pkg::reg_idx_t         rd;
        rv_isa_pkg::reg_idx_t         rs1;
        rv_isa_pkg::reg_idx_t         rs2;
        logic [rv_isa_pkg::XLEN-1:0]  imm;  // sign extended
    } decoded_op_t;

endpackage

// File: src/decode_unit.sv
module decode_unit (
    input  logic                  clk,
    input  logic                  rst,
    fetch_if.consumer             in,
    decode_if.decode              redir,
    output logic                  out_valid,
    input  logic                  out_ready,
    output core_pkg::decoded_op_t out_op
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic            valid_q;
    epoch_t          epoch_q;
    instr_t          instr;
    rv_opcode_t      opcode;
    op_class_t       op_class;
    logic            epoch_ok;
    logic            accept;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm;
    decoded_op_t     dec;

    assign instr  = in.instr;
    assign opcode = rv_opcode_t'(instr[OPCODE_W-1:0]);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        op_class = op_illegal;
        imm      = '0;
        case (opcode)
            opc_lui:    begin op_class = op_lui;     imm = imm_u; end
            opc_auipc:  begin op_class = op_auipc;   imm = imm_u; end
            opc_jal:    begin op_class = op_jal;     imm = imm_j; end
            opc_jalr:   begin op_class = op_jalr;    imm = imm_i; end
            opc_branch: begin op_class = op_branch;  imm = imm_b; end
            opc_load:   begin op_class = op_load;    imm = imm_i; end
            opc_store:  begin op_class = op_store;   imm = imm_s; end
            opc_op_imm: begin op_class = op_alu_imm; imm = imm_i; end
            opc_op:     op_class = op_alu_reg;       // register form has no imm
            opc_system: begin op_class = op_system;  imm = imm_i; end
            default:    op_class = op_illegal;
        endcase
    end

    assign dec = '{
        pc:       in.op.pc,
        op_class: op_class,
        rd:       instr[11:7],
        rs1:      instr[19:15],
        rs2:      instr[24:20],
        imm:      imm
    };

    // a held op from before the last redirect is not presented
    assign out_valid = valid_q && (epoch_q == redir.cur_epoch);

    assign in.ready = !out_valid || out_ready;
    assign accept   = in.valid && in.ready;
    assign epoch_ok = in.op.epoch == redir.cur_epoch;

    assign redir.jal_valid  = accept && epoch_ok && (op_class == op_jal);
    assign redir.jal_target = '{base_addr: in.op.pc, offset: imm_j};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in.ready) begin
            valid_q <= in.valid && epoch_ok;  // also clears a stale held op
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_op <= dec;
            // a jal opens the epoch that it creates itself
            epoch_q <= redir.jal_valid ? epoch_t'(in.op.epoch + 1'b1) : in.op.epoch;
        end
    end

    // imem keeps offering the same item while decode stalls it
    a_in_hold: assert property (
        @(posedge clk) disable iff (rst)
        (in.valid && !in.ready) |=> (in.valid && $stable(in.op) && $stable(in.instr))
    ) else $error("stalled instruction changed before it was accepted");

endmodule

// File: src/fetch_unit.sv
module fetch_unit #(
    parameter core_pkg::pc_t START_ADDR = '0
) (
    input  logic                clk,
    input  logic                rst,
    fetch_if.producer           req,
    decode_if.fetch             redir,
    input  logic                branch_valid,
    input  logic                branch_taken,
    input  core_pkg::redirect_t branch_target
);
    import core_pkg::*;

    fetch_op_t op_q;
    logic      valid_q;
    logic      take_jal;
    logic      take_branch;
    logic      advance;
    pc_t       next_pc;

    // jal from decode wins over an external branch
    assign take_jal    = redir.jal_valid;
    assign take_branch = branch_valid && branch_taken && !redir.jal_valid;
    assign advance     = valid_q && req.ready;

    always_comb begin
        next_pc = op_q.pc;
        if (take_jal) begin
            next_pc = redir.jal_target.base_addr + redir.jal_target.offset;
        end else if (take_branch) begin
            next_pc = branch_target.base_addr + branch_target.offset;
        end else if (advance) begin
            next_pc = op_q.pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q.pc    <= START_ADDR;
            op_q.epoch <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= 1'b1;
            op_q.pc <= next_pc;  // a redirect overrides a stalled request
            if (take_jal || take_branch) begin
                op_q.epoch <= op_q.epoch + 1'b1;
            end
        end
    end

    assign req.valid       = valid_q;
    assign req.op          = op_q;
    assign req.instr       = '0;  // filled in by imem
    assign redir.cur_epoch = op_q.epoch;

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        req.op.pc[1:0] == 2'b00
    ) else $error("fetch pc not word aligned: %h", req.op.pc);

endmodule

// File: src/frontend_top.sv
module frontend_top #(
    parameter core_pkg::pc_t START_ADDR = '0,
    parameter int            IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
    input  rv_isa_pkg::instr_t            prog_data,
    input  logic                          branch_valid,
    input  logic                          branch_taken,
    input  core_pkg::pc_t                 branch_base,
    input  core_pkg::pc_t                 branch_offset,
    output logic                          out_valid,
    input  logic                          out_ready,
    output core_pkg::pc_t                 out_pc,
    output rv_isa_pkg::op_class_t         out_class,
    output rv_isa_pkg::reg_idx_t          out_rd,
    output rv_isa_pkg::reg_idx_t          out_rs1,
    output rv_isa_pkg::reg_idx_t          out_rs2,
    output logic [rv_isa_pkg::XLEN-1:0]   out_imm
);
    import core_pkg::*;

    fetch_if  f2m ();  // fetch -> imem
    fetch_if  m2d ();  // imem -> decode
    decode_if d2f ();

    redirect_t   branch_target;
    decoded_op_t out_op;

    assign branch_target = '{base_addr: branch_base, offset: branch_offset};

    fetch_unit #(
        .START_ADDR(START_ADDR)
    ) u_fetch (
        .clk,
        .rst,
        .req          (f2m.producer),
        .redir        (d2f.fetch),
        .branch_valid,
        .branch_taken,
        .branch_target
    );

    imem_stage #(
        .IMEM_WORDS(IMEM_WORDS)
    ) u_imem (
        .clk,
        .rst,
        .req       (f2m.consumer),
        .resp      (m2d.producer),
        .prog_we,
        .prog_addr,
        .prog_data
    );

    decode_unit u_decode (
        .clk,
        .rst,
        .in        (m2d.consumer),
        .redir     (d2f.decode),
        .out_valid,
        .out_ready,
        .out_op
    );

    assign out_pc    = out_op.pc;
    assign out_class = out_op.op_class;
    assign out_rd    = out_op.rd;
    assign out_rs1   = out_op.rs1;
    assign out_rs2   = out_op.rs2;
    assign out_imm   = out_op.imm;

endmodule

// File: src/imem_stage.sv
module imem_stage #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                              clk,
    input  logic                              rst,
    fetch_if.consumer                         req,
    fetch_if.producer                         resp,
    input  logic                              prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0]     prog_addr,
    input  rv_isa_pkg::instr_t                prog_data
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int ADDR_W = $clog2(IMEM_WORDS);

    instr_t            mem [IMEM_WORDS];
    logic [ADDR_W-1:0] rd_idx;
    logic              load;
    logic              valid_q;
    fetch_op_t         op_q;
    instr_t            instr_q;

    if ((1 << ADDR_W) != IMEM_WORDS) begin : g_depth_check
        $error("IMEM_WORDS must be a power of two");
    end

    assign rd_idx    = req.op.pc[ADDR_W+1:2];  // word index, upper pc bits wrap
    assign req.ready = !valid_q || resp.ready;
    assign load      = req.valid && req.ready;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // read port doubles as the output register, held on stall
    always_ff @(posedge clk) begin
        if (load) begin
            instr_q <= mem[rd_idx];
            op_q    <= req.op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (req.ready) begin
            valid_q <= req.valid;
        end
    end

    assign resp.valid = valid_q;
    assign resp.op    = op_q;
    assign resp.instr = instr_q;

    // program loading must not race a fetch of the same word
    a_no_load_collision: assert property (
        @(posedge clk) disable iff (rst)
        (prog_we && load) |-> (prog_addr != rd_idx)
    ) else $error("imem write collides with read at word %0d", prog_addr);

endmodule

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN      = 32;
    localparam int ILEN      = 32;  // no compressed encodings
    localparam int OPCODE_W  = 7;
    localparam int REG_IDX_W = 5;

    typedef logic [ILEN-1:0]      instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // major opcode field, instr[6:0]
    typedef enum logic [OPCODE_W-1:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } rv_opcode_t;

    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_alu_imm,
        op_alu_reg,
        op_system,
        op_illegal
    } op_class_t;

endpackage

// File: src/stage_if.sv
// stream link between stages, instr only meaningful after imem
interface fetch_if;
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic      valid;
    logic      ready;
    fetch_op_t op;
    instr_t    instr;

    modport producer (output valid, output op, output instr, input ready);
    modport consumer (input valid, input op, input instr, output ready);
endinterface

// decode -> fetch control, no handshake
interface decode_if;
    import core_pkg::*;

    logic      jal_valid;
    redirect_t jal_target;
    epoch_t    cur_epoch;

    modport fetch (
        input  jal_valid,
        input  jal_target,
        output cur_epoch
    );
    modport decode (
        output jal_valid,
        output jal_target,
        input  cur_epoch
    );
endinterface

// File: tests/clock_gen.sv
module clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // released just after the edge like other inputs
    end
endmodule

// File: tests/tb_frontend.sv
module tb_frontend;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int IMEM_WORDS = 256;
    localparam int ADDR_W     = $clog2(IMEM_WORDS);
    localparam int PROG_WORDS = 32;
    localparam int TOTAL_OUT  = 16 + 16 + 6 + 10 + 10;
    // 20 cycles per expected output plus program loads and resets
    localparam int MAX_CYCLES = 20 * TOTAL_OUT + 6 * (PROG_WORDS + 8);

    logic              clk;
    logic              gen_rst;
    logic              hold_rst;
    logic              prog_we;
    logic [ADDR_W-1:0] prog_addr;
    instr_t            prog_data;
    logic              branch_valid;
    logic              branch_taken;
    pc_t               branch_base;
    pc_t               branch_offset;
    logic              out_valid;
    logic              out_ready;
    pc_t               out_pc;
    op_class_t         out_class;
    reg_idx_t          out_rd;
    reg_idx_t          out_rs1;
    reg_idx_t          out_rs2;
    logic [XLEN-1:0]   out_imm;

    integer      seed;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          redirect_mark;
    instr_t      prog [PROG_WORDS];
    decoded_op_t got[$];

    clock_gen #(.PERIOD(8), .RESET_CYCLES(4)) u_clk (.clk(clk), .rst(gen_rst));

    frontend_top #(
        .START_ADDR(32'h0),
        .IMEM_WORDS(IMEM_WORDS)
    ) DUT (
        .clk           (clk),
        .rst           (gen_rst | hold_rst),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .branch_valid  (branch_valid),
        .branch_taken  (branch_taken),
        .branch_base   (branch_base),
        .branch_offset (branch_offset),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_class     (out_class),
        .out_rd        (out_rd),
        .out_rs1       (out_rs1),
        .out_rs2       (out_rs2),
        .out_imm       (out_imm)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run exceeded %0d cycles without finishing", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // expected decode built straight from the RV32I field layout
    function automatic decoded_op_t ref_decode(input instr_t w, input pc_t pc);
        decoded_op_t d;
        logic [31:0] i_imm;
        logic [12:0] b13;
        logic [20:0] j21;
        i_imm = 32'($signed(w) >>> 20);
        b13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        d.pc = pc;
        d.rd = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.imm = '0;
        d.op_class = op_illegal;
        case (w[6:0])
            7'h37: begin d.op_class = op_lui;     d.imm = {w[31:12], 12'h000}; end
            7'h17: begin d.op_class = op_auipc;   d.imm = {w[31:12], 12'h000}; end
            7'h6f: begin d.op_class = op_jal;     d.imm = 32'($signed(j21)); end
            7'h67: begin d.op_class = op_jalr;    d.imm = i_imm; end
            7'h63: begin d.op_class = op_branch;  d.imm = 32'($signed(b13)); end
            7'h03: begin d.op_class = op_load;    d.imm = i_imm; end
            7'h23: begin d.op_class = op_store;   d.imm = {i_imm[31:5], w[11:7]}; end
            7'h13: begin d.op_class = op_alu_imm; d.imm = i_imm; end
            7'h33: d.op_class = op_alu_reg;
            7'h73: begin d.op_class = op_system;  d.imm = i_imm; end
            default: d.op_class = op_illegal;
        endcase
        return d;
    endfunction

    function automatic instr_t word_at(input pc_t pc);
        return prog[pc[6:2]];
    endfunction

    task automatic check_pc(input pc_t got_pc, input pc_t exp_pc, input string what);
        if (got_pc !== exp_pc) begin
            $display("MISMATCH at %0t: %s pc %h, expected %h", $time, what, got_pc, exp_pc);
            errors++;
        end
    endtask

    task automatic check_class(input op_class_t got_c, input op_class_t exp_c,
                               input string what);
        if (got_c !== exp_c) begin
            $display("MISMATCH at %0t: %s class %s, expected %s", $time, what,
                     got_c.name(), exp_c.name());
            errors++;
        end
    endtask

    task automatic check_op(input decoded_op_t got_op, input decoded_op_t exp_op,
                            input string what);
        if (got_op !== exp_op) begin
            $display("MISMATCH at %0t: %s op %h (pc %h), expected %h", $time, what,
                     got_op, got_op.pc, exp_op);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // holds reset while prog[] is written and releases it after the last word
    task automatic load_program();
        next_cycle();
        hold_rst = 1'b1;
        out_ready = 1'b0;
        branch_valid = 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_we = 1'b1;
            prog_addr = ADDR_W'(i);
            prog_data = prog[i];
            next_cycle();
        end
        prog_we = 1'b0;
        hold_rst = 1'b0;
    endtask

    task automatic make_random_program();
        logic [31:0] r;
        instr_t      w;
        for (int i = 0; i < PROG_WORDS; i++) begin
            r = $random(seed);
            w = $random(seed);
            case (r % 6)
                0: w[6:0] = 7'h37;
                1: w[6:0] = 7'h17;
                2: w[6:0] = 7'h03;
                3: w[6:0] = 7'h23;
                4: w[6:0] = 7'h13;
                default: w[6:0] = 7'h33;
            endcase
            prog[i] = w;
        end
    endtask

    task automatic fill_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {12'(i), 5'd0, 3'b000, 5'(i), 7'h13};  // addi xi, x0, i
        end
    endtask

    // a strobe fires once the accepted count reaches nt_at or tk_at (-1 never fires)
    task automatic collect(input int n, input bit toggle_ready, input int nt_at,
                           input int tk_at, input pc_t base, input pc_t off);
        int          budget;
        bit          nt_done;
        bit          tk_done;
        logic [31:0] r;
        got.delete();
        redirect_mark = -1;
        budget = 20 * n;
        nt_done = 1'b0;
        tk_done = 1'b0;
        while (got.size() < n && budget > 0) begin
            r = $random(seed);
            out_ready = toggle_ready ? r[0] : 1'b1;
            branch_valid = 1'b0;
            branch_taken = 1'b0;
            branch_base = base;
            branch_offset = off;
            if (!nt_done && got.size() == nt_at) begin
                branch_valid = 1'b1;
                nt_done = 1'b1;
            end else if (!tk_done && got.size() == tk_at) begin
                branch_valid = 1'b1;
                branch_taken = 1'b1;
                tk_done = 1'b1;
            end
            @(negedge clk);
            if (out_valid && out_ready) begin
                got.push_back(decoded_op_t'{pc: out_pc, op_class: out_class, rd: out_rd,
                                            rs1: out_rs1, rs2: out_rs2, imm: out_imm});
            end
            if (branch_valid && branch_taken) redirect_mark = got.size();
            next_cycle();
            budget--;
        end
        branch_valid = 1'b0;
        branch_taken = 1'b0;
        out_ready = 1'b0;
        if (got.size() < n) begin
            $display("error at %0t: only %0d of %0d outputs arrived within %0d cycles",
                     $time, got.size(), n, 20 * n);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        tests_run++;
        if (errors == e0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - e0);
            tests_failed++;
        end
    endtask

    task automatic test_sequential();
        int e0;
        e0 = errors;
        make_random_program();
        load_program();
        collect(16, 1'b0, -1, -1, '0, '0);
        for (int i = 0; i < got.size(); i++) begin
            check_pc(got[i].pc, 32'(4 * i), "sequential");
            check_op(got[i], ref_decode(prog[i], 32'(4 * i)), "sequential");
        end
        finish_test("sequential stream", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = errors;
        load_program();  // same program as the sequential test
        collect(16, 1'b1, -1, -1, '0, '0);
        for (int i = 0; i < got.size(); i++) begin
            check_pc(got[i].pc, 32'(4 * i), "backpressure");
            check_op(got[i], ref_decode(prog[i], 32'(4 * i)), "backpressure");
        end
        finish_test("back-pressure", e0);
    endtask

    task automatic test_jal();
        int  e0;
        pc_t exp_pc [6] = '{32'd0, 32'd4, 32'd8, 32'd40, 32'd44, 32'd48};
        e0 = errors;
        fill_program();
        prog[2] = 32'h020000ef;  // jal x1, +32
        load_program();
        collect(6, 1'b0, -1, -1, '0, '0);
        for (int i = 0; i < got.size(); i++) begin
            check_pc(got[i].pc, exp_pc[i], "jal");
            check_op(got[i], ref_decode(word_at(exp_pc[i]), exp_pc[i]), "jal");
        end
        if (got.size() > 2) check_class(got[2].op_class, op_jal, "jal");
        finish_test("jal redirect", e0);
    endtask

    task automatic test_branch();
        int  e0;
        pc_t exp;
        e0 = errors;
        fill_program();
        load_program();
        collect(10, 1'b0, 2, 5, 32'd0, 32'd64);
        if (redirect_mark < 0) begin
            $display("error at %0t: taken branch strobe was never driven", $time);
            errors++;
        end
        for (int i = 0; i < got.size(); i++) begin
            exp = (i < redirect_mark) ? 32'(4 * i) : 32'(64 + 4 * (i - redirect_mark));
            check_pc(got[i].pc, exp, "branch");
            check_op(got[i], ref_decode(word_at(exp), exp), "branch");
        end
        finish_test("taken and not-taken branch", e0);
    endtask

    task automatic test_illegal_reset();
        int     e0;
        instr_t w;
        e0 = errors;
        fill_program();
        w = $random(seed);
        prog[1] = {w[31:7], 7'h00};
        w = $random(seed);
        prog[3] = {w[31:7], 7'h7f};
        w = $random(seed);
        prog[4] = {w[31:7], 7'h0b};  // custom-0 space
        load_program();
        collect(6, 1'b0, -1, -1, '0, '0);
        for (int i = 0; i < got.size(); i++) begin
            check_op(got[i], ref_decode(prog[i], 32'(4 * i)), "illegal");
            if (i == 1 || i == 3 || i == 4) check_class(got[i].op_class, op_illegal, "illegal");
        end
        out_ready = 1'b1;  // stream still moving when reset hits
        hold_rst = 1'b1;
        next_cycle();
        next_cycle();
        hold_rst = 1'b0;
        collect(4, 1'b0, -1, -1, '0, '0);
        for (int i = 0; i < got.size(); i++) begin
            check_pc(got[i].pc, 32'(4 * i), "restart");
            check_op(got[i], ref_decode(prog[i], 32'(4 * i)), "restart");
        end
        finish_test("illegal and reset", e0);
    endtask

    initial begin
        seed = 63600;
        hold_rst = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        branch_valid = 1'b0;
        branch_taken = 1'b0;
        branch_base = '0;
        branch_offset = '0;
        out_ready = 1'b0;

        test_sequential();
        test_backpressure();
        test_jal();
        test_branch();
        test_illegal_reset();

        $display("tests run %0d, failed %0d, errors %0d, cycles %0d",
                 tests_run, tests_failed, errors, cycles);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end
endmodule
